// File: source/board_pkg.sv
package board_pkg;

  //////////////////////////////////////////////////////////////////////
  // qmem bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int QMEM_AW = 22;                    // Byte address width
  localparam int M_DW    = 32;                    // Master data width
  localparam int S_DW    = 16;                    // Slave data width
  localparam int M_SW    = M_DW / 8;              // Master byte selects
  localparam int S_SW    = S_DW / 8;              // Slave byte selects

  typedef logic [M_DW-1:0]    m_dat_t;            // 32-bit master word
  typedef logic [S_DW-1:0]    s_dat_t;            // 16-bit slave word
  typedef logic [M_SW-1:0]    m_sel_t;
  typedef logic [S_SW-1:0]    s_sel_t;
  typedef logic [QMEM_AW-1:0] qmem_adr_t;

  localparam qmem_adr_t HALF_STEP = qmem_adr_t'(2); // Upper half-word offset

  // Bridge sequencing, one half-word per state
  typedef enum logic [1:0] {
    IDLE,                                         // Waiting for m_cs
    LOW,                                          // Low half on slave bus
    HIGH,                                         // High half on slave bus
    DONE                                          // m_ack cycle
  } bridge_state_t;

  //////////////////////////////////////////////////////////////////////
  // Board constants
  //////////////////////////////////////////////////////////////////////

  localparam int SYNC_STAGES = 2;                 // Two flops per input
  localparam int SW_W        = 10;                // SW[9:0]
  localparam int KEY_W       = 4;                 // KEY[3:0]
  localparam int STAT_W      = 4;
  localparam int SEG_W       = 7;                 // Segments g..a
  localparam int TRACK_W     = 8;
  localparam int LEDG_W      = 8;
  localparam int FIFO_CNT    = 4;                 // Floppy wr/rd, hd wr/rd

  localparam int SW_UART_SEL = 5;                 // sw5 picks UART owner
  localparam int SPI_SD_CS   = 0;                 // SD card chip-select bit

  typedef logic [TRACK_W-1:0] track_t;
  typedef logic [STAT_W-1:0]  nibble_t;

  localparam int ACT_HOLD_CYCLES = 16;            // LED stretch length
  localparam int ACT_CNT_W       = $clog2(ACT_HOLD_CYCLES + 1);

  typedef logic [ACT_CNT_W-1:0] act_cnt_t;

endpackage

// File: source/qmem_if.sv
`timescale 1ns/1ns

interface qmem_if #(
  parameter int DW = 32                           // Data width, 16 or 32
) ();

  import board_pkg::*;

  qmem_adr_t         adr;                         // Byte address
  logic              cs;                          // Held until ack
  logic              we;
  logic [DW/8-1:0]   sel;                         // Byte selects
  logic [DW-1:0]     dat_w;
  logic [DW-1:0]     dat_r;                       // Valid with ack
  logic              ack;                         // One cycle
  logic              err;                         // Valid with ack

  modport master (
    output adr, cs, we, sel, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  adr, cs, we, sel, dat_w,
    output dat_r, ack, err
  );

endinterface

// File: source/board_controls.sv
`timescale 1ns/1ns

module board_controls (
  input  logic                      clk_50,
  input  logic                      i_rst_n,
  // board inputs
  input  logic [board_pkg::SW_W-1:0]  i_sw,         // Toggle switches
  input  logic [board_pkg::KEY_W-1:0] i_key,        // Pushbuttons
  input  board_pkg::nibble_t        i_sys_status,   // Async status bits
  // UART
  input  logic                      i_uart_rxd,     // Board RS232 in
  output logic                      o_uart_txd,     // Board RS232 out
  input  logic                      i_ctrl_txd,
  output logic                      o_ctrl_rxd,
  input  logic                      i_chip_txd,
  output logic                      o_chip_rxd,
  // SPI
  input  board_pkg::nibble_t        i_spi_cs_n,
  input  logic                      i_sd_dat,       // SD card MISO
  input  logic                      i_chip_sdo,     // Chipset SPI out
  output logic                      o_spi_di,
  // synchronized values
  output logic [board_pkg::SW_W-1:0]  o_sw_sync,
  output logic [board_pkg::KEY_W-1:0] o_key_sync,
  output board_pkg::nibble_t        o_sys_status_sync
);

  import board_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////////////////////////

  // All board inputs share one flop chain {status, key, sw}
  logic [STAT_W+KEY_W+SW_W-1:0] sync_q [SYNC_STAGES];
  logic                         uart_sel;

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;                                // Sync values 0 after reset
      end
    end else begin
      sync_q[0] <= {i_sys_status, i_key, i_sw};         // First stage, may go metastable
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign o_sw_sync         = sync_q[SYNC_STAGES-1][SW_W-1:0];
  assign o_key_sync        = sync_q[SYNC_STAGES-1][SW_W +: KEY_W];
  assign o_sys_status_sync = sync_q[SYNC_STAGES-1][SW_W+KEY_W +: STAT_W];

  //////////////////////////////////////////////////////////////////////
  // UART and SPI routing
  //////////////////////////////////////////////////////////////////////

  assign uart_sel   = o_sw_sync[SW_UART_SEL];           // 1 = control port owns UART

  assign o_uart_txd = uart_sel ? i_ctrl_txd : i_chip_txd;
  assign o_ctrl_rxd = uart_sel ? i_uart_rxd : 1'b1;     // Idle high when deselected
  assign o_chip_rxd = uart_sel ? 1'b1       : i_uart_rxd;

  // SD card drives MISO only while its select is low
  assign o_spi_di   = !i_spi_cs_n[SPI_SD_CS] ? i_sd_dat : i_chip_sdo;

endmodule

// File: source/qmem_bridge.sv
`timescale 1ns/1ns

module qmem_bridge (
  input  logic   clk_50,
  input  logic   i_rst_n,
  qmem_if.slave  m_bus,                           // 32-bit side
  qmem_if.master s_bus                            // 16-bit side
);

  import board_pkg::*;

  bridge_state_t state_q;
  qmem_adr_t     adr_q;                           // Captured request
  logic          we_q;
  m_sel_t        sel_q;
  m_dat_t        dat_w_q;
  s_dat_t        rd_lo_q;                         // First half-word read
  s_dat_t        rd_hi_q;                         // Second half-word read
  logic          err_q;                           // OR of both slave errors
  logic          hi_half;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (m_bus.cs) begin
            state_q <= LOW;                       // Low half goes out next cycle
            err_q   <= 1'b0;
          end
        end
        LOW: begin
          if (s_bus.ack) begin
            state_q <= HIGH;
            err_q   <= s_bus.err;
          end
        end
        HIGH: begin
          if (s_bus.ack) begin
            state_q <= DONE;
            err_q   <= err_q | s_bus.err;
          end
        end
        DONE:    state_q <= IDLE;                 // m_cs ignored here
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request and read data capture
  always_ff @(posedge clk_50) begin
    if (state_q == IDLE && m_bus.cs) begin
      adr_q   <= m_bus.adr;
      we_q    <= m_bus.we;
      sel_q   <= m_bus.sel;
      dat_w_q <= m_bus.dat_w;
    end
    if (state_q == LOW && s_bus.ack) begin
      rd_lo_q <= s_bus.dat_r;
    end
    if (state_q == HIGH && s_bus.ack) begin
      rd_hi_q <= s_bus.dat_r;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus outputs
  //////////////////////////////////////////////////////////////////////

  assign hi_half     = (state_q == HIGH);

  // Slave fields come from registers only, so they hold under back-pressure
  assign s_bus.cs    = (state_q == LOW) || hi_half;
  assign s_bus.adr   = hi_half ? adr_q + HALF_STEP : adr_q;
  assign s_bus.we    = we_q;
  assign s_bus.sel   = hi_half ? sel_q[3:2] : sel_q[1:0];
  assign s_bus.dat_w = hi_half ? dat_w_q[31:16] : dat_w_q[15:0];

  assign m_bus.ack   = (state_q == DONE);         // Single cycle
  assign m_bus.dat_r = {rd_hi_q, rd_lo_q};
  assign m_bus.err   = err_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Slave side must hold its request until the slave acks
  a_s_stable : assert property (
    @(posedge clk_50) disable iff (!i_rst_n)
    s_bus.cs && !s_bus.ack |=>
      s_bus.cs && $stable({s_bus.adr, s_bus.we, s_bus.sel, s_bus.dat_w})
  ) else $error("qmem_bridge: slave fields changed before s_ack");

  a_m_ack_pulse : assert property (
    @(posedge clk_50) disable iff (!i_rst_n)
    m_bus.ack |=> !m_bus.ack
  ) else $error("qmem_bridge: m_ack held for two cycles");

endmodule

// File: source/board_indicators.sv
`timescale 1ns/1ns

module board_indicators (
  input  logic                          clk_50,
  input  logic                          i_rst_n,
  input  board_pkg::track_t             i_track,        // Floppy track number
  input  board_pkg::nibble_t            i_ctrl_status,
  input  board_pkg::nibble_t            i_sys_status,
  input  logic                          i_floppy_wr,    // FIFO activity pulses
  input  logic                          i_floppy_rd,
  input  logic                          i_hd_wr,
  input  logic                          i_hd_rd,
  output logic [board_pkg::SEG_W-1:0]   o_hex0,         // Track low nibble
  output logic [board_pkg::SEG_W-1:0]   o_hex1,         // Track high nibble
  output logic [board_pkg::SEG_W-1:0]   o_hex2,         // Ctrl status
  output logic [board_pkg::SEG_W-1:0]   o_hex3,         // Sys status
  output logic [board_pkg::LEDG_W-1:0]  o_led_g
);

  import board_pkg::*;

  logic [FIFO_CNT-1:0] fifo_pulse;
  logic [FIFO_CNT-1:0] act_led;

  //////////////////////////////////////////////////////////////////////
  // Seven-segment digits
  //////////////////////////////////////////////////////////////////////

  // Active low, bit order {g,f,e,d,c,b,a}
  function automatic logic [SEG_W-1:0] hex_seg(input nibble_t val);
    case (val)
      4'h0:    hex_seg = 7'b1000000;
      4'h1:    hex_seg = 7'b1111001;
      4'h2:    hex_seg = 7'b0100100;
      4'h3:    hex_seg = 7'b0110000;
      4'h4:    hex_seg = 7'b0011001;
      4'h5:    hex_seg = 7'b0010010;
      4'h6:    hex_seg = 7'b0000010;
      4'h7:    hex_seg = 7'b1111000;
      4'h8:    hex_seg = 7'b0000000;
      4'h9:    hex_seg = 7'b0010000;
      4'ha:    hex_seg = 7'b0001000;
      4'hb:    hex_seg = 7'b0000011;              // Lower case b
      4'hc:    hex_seg = 7'b1000110;
      4'hd:    hex_seg = 7'b0100001;              // Lower case d
      4'he:    hex_seg = 7'b0000110;
      default: hex_seg = 7'b0001110;              // F
    endcase
  endfunction

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_hex0 <= hex_seg(4'h0);                    // All digits read 0
      o_hex1 <= hex_seg(4'h0);
      o_hex2 <= hex_seg(4'h0);
      o_hex3 <= hex_seg(4'h0);
    end else begin
      o_hex0 <= hex_seg(i_track[3:0]);
      o_hex1 <= hex_seg(i_track[7:4]);
      o_hex2 <= hex_seg(i_ctrl_status);
      o_hex3 <= hex_seg(i_sys_status);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Activity LEDs
  //////////////////////////////////////////////////////////////////////

  assign fifo_pulse = {i_hd_rd, i_hd_wr, i_floppy_rd, i_floppy_wr};

  // One stretch counter per FIFO pulse
  for (genvar g = 0; g < FIFO_CNT; g++) begin : g_act
    act_cnt_t cnt_q;

    always_ff @(posedge clk_50 or negedge i_rst_n) begin
      if (!i_rst_n) begin
        cnt_q <= '0;
      end else if (fifo_pulse[g]) begin
        cnt_q <= act_cnt_t'(ACT_HOLD_CYCLES);     // Retrigger on every pulse
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    assign act_led[g] = (cnt_q != '0);

    a_led_rise : assert property (
      @(posedge clk_50) disable iff (!i_rst_n)
      $rose(act_led[g]) |-> $past(fifo_pulse[g])
    ) else $error("board_indicators: LED %0d rose without a FIFO pulse", g);
  end

  assign o_led_g = {{(LEDG_W-FIFO_CNT){1'b0}}, act_led}; // Upper LEDs off

endmodule

// File: source/de1_board_top.sv
`timescale 1ns/1ns

module de1_board_top (
  input  logic                          clk_50,
  input  logic                          i_rst_n,
  // board controls
  input  logic [board_pkg::SW_W-1:0]    i_sw,
  input  logic [board_pkg::KEY_W-1:0]   i_key,
  input  board_pkg::nibble_t            i_sys_status,
  input  logic                          i_uart_rxd,
  output logic                          o_uart_txd,
  input  logic                          i_ctrl_txd,
  output logic                          o_ctrl_rxd,
  input  logic                          i_chip_txd,
  output logic                          o_chip_rxd,
  input  board_pkg::nibble_t            i_spi_cs_n,
  input  logic                          i_sd_dat,
  input  logic                          i_chip_sdo,
  output logic                          o_spi_di,
  output logic [board_pkg::KEY_W-1:0]   o_key_sync,
  // qmem master, 32 bit
  input  board_pkg::qmem_adr_t          i_m_adr,
  input  logic                          i_m_cs,
  input  logic                          i_m_we,
  input  board_pkg::m_sel_t             i_m_sel,
  input  board_pkg::m_dat_t             i_m_dat_w,
  output board_pkg::m_dat_t             o_m_dat_r,
  output logic                          o_m_ack,
  output logic                          o_m_err,
  // qmem slave, 16 bit
  output board_pkg::qmem_adr_t          o_s_adr,
  output logic                          o_s_cs,
  output logic                          o_s_we,
  output board_pkg::s_sel_t             o_s_sel,
  output board_pkg::s_dat_t             o_s_dat_w,
  input  board_pkg::s_dat_t             i_s_dat_r,
  input  logic                          i_s_ack,
  input  logic                          i_s_err,
  // indicators
  input  board_pkg::track_t             i_track,
  input  board_pkg::nibble_t            i_ctrl_status,
  input  logic                          i_floppy_wr,
  input  logic                          i_floppy_rd,
  input  logic                          i_hd_wr,
  input  logic                          i_hd_rd,
  output logic [board_pkg::SEG_W-1:0]   o_hex0,
  output logic [board_pkg::SEG_W-1:0]   o_hex1,
  output logic [board_pkg::SEG_W-1:0]   o_hex2,
  output logic [board_pkg::SEG_W-1:0]   o_hex3,
  output logic [board_pkg::LEDG_W-1:0]  o_led_g,
  output logic [board_pkg::SW_W-1:0]    o_ledr          // Synced switches
);

  import board_pkg::*;

  nibble_t sys_status_sync;

  qmem_if #(.DW(M_DW)) m_if ();                   // Master side of bridge
  qmem_if #(.DW(S_DW)) s_if ();                   // Slave side of bridge

  assign m_if.adr   = i_m_adr;
  assign m_if.cs    = i_m_cs;
  assign m_if.we    = i_m_we;
  assign m_if.sel   = i_m_sel;
  assign m_if.dat_w = i_m_dat_w;
  assign o_m_dat_r  = m_if.dat_r;
  assign o_m_ack    = m_if.ack;
  assign o_m_err    = m_if.err;

  assign o_s_adr    = s_if.adr;
  assign o_s_cs     = s_if.cs;
  assign o_s_we     = s_if.we;
  assign o_s_sel    = s_if.sel;
  assign o_s_dat_w  = s_if.dat_w;
  assign s_if.dat_r = i_s_dat_r;
  assign s_if.ack   = i_s_ack;
  assign s_if.err   = i_s_err;

  //////////////////////////////////////////////////////////////////////
  // Submodules
  //////////////////////////////////////////////////////////////////////

  board_controls u_controls (
    .clk_50            (clk_50),
    .i_rst_n           (i_rst_n),
    .i_sw              (i_sw),
    .i_key             (i_key),
    .i_sys_status      (i_sys_status),
    .i_uart_rxd        (i_uart_rxd),
    .o_uart_txd        (o_uart_txd),
    .i_ctrl_txd        (i_ctrl_txd),
    .o_ctrl_rxd        (o_ctrl_rxd),
    .i_chip_txd        (i_chip_txd),
    .o_chip_rxd        (o_chip_rxd),
    .i_spi_cs_n        (i_spi_cs_n),
    .i_sd_dat          (i_sd_dat),
    .i_chip_sdo        (i_chip_sdo),
    .o_spi_di          (o_spi_di),
    .o_sw_sync         (o_ledr),                  // Switch state on red LEDs
    .o_key_sync        (o_key_sync),
    .o_sys_status_sync (sys_status_sync)
  );

  qmem_bridge u_bridge (
    .clk_50  (clk_50),
    .i_rst_n (i_rst_n),
    .m_bus   (m_if.slave),
    .s_bus   (s_if.master)
  );

  board_indicators u_indicators (
    .clk_50        (clk_50),
    .i_rst_n       (i_rst_n),
    .i_track       (i_track),
    .i_ctrl_status (i_ctrl_status),
    .i_sys_status  (sys_status_sync),             // 2 sync cycles + 1 reg
    .i_floppy_wr   (i_floppy_wr),
    .i_floppy_rd   (i_floppy_rd),
    .i_hd_wr       (i_hd_wr),
    .i_hd_rd       (i_hd_rd),
    .o_hex0        (o_hex0),
    .o_hex1        (o_hex1),
    .o_hex2        (o_hex2),
    .o_hex3        (o_hex3),
    .o_led_g       (o_led_g)
  );

endmodule

// File: verif/tb_de1_board_top.sv
`timescale 1ns/1ns

module tb_de1_board_top;

  import board_pkg::*;

  localparam int TIMEOUT   = 40;                  // Cycles allowed per bus access
  localparam int MEM_WORDS = 1024;                // 16-bit words in the model
  localparam int NROWS     = 12;

  typedef enum logic [1:0] {K_WR, K_RD, K_DISP, K_ROUTE} kind_t;

  typedef struct packed {
    kind_t     kind;
    qmem_adr_t adr;
    m_sel_t    sel;
    m_dat_t    dat;                               // Write data or board inputs
    m_dat_t    want;                              // Read data or board outputs
    logic      err;                               // Expect m_err
    qmem_adr_t bad_adr;                           // Half-word that answers with s_err
  } row_t;

  // Route dat bits {key[3:0], chip_txd, ctrl_txd, sdo, sd, cs_n0, rxd, sw5}
  // Route want bits {key_sync[3:0], sw5, uart_txd, spi_di, chip_rxd, ctrl_rxd}
  row_t rows [NROWS] = '{
    '{K_WR,    22'h000100, 4'hf, 32'h1234_5678, 32'h0000_0000, 1'b0, 22'h000000},
    '{K_RD,    22'h000100, 4'hf, 32'h0000_0000, 32'h1234_5678, 1'b0, 22'h000000},
    '{K_WR,    22'h000100, 4'h5, 32'haabb_ccdd, 32'h0000_0000, 1'b0, 22'h000000},
    '{K_RD,    22'h000100, 4'hf, 32'h0000_0000, 32'h12bb_56dd, 1'b0, 22'h000000}, // Merged bytes
    '{K_WR,    22'h000204, 4'hf, 32'hdead_beef, 32'h0000_0000, 1'b0, 22'h000000},
    '{K_RD,    22'h000204, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0, 22'h000000},
    '{K_WR,    22'h0003f0, 4'hf, 32'h55aa_55aa, 32'h0000_0000, 1'b1, 22'h0003f0}, // Low half
    '{K_RD,    22'h0003f0, 4'hf, 32'h0000_0000, 32'h0000_0000, 1'b1, 22'h0003f2}, // High half
    '{K_DISP,  22'h000000, 4'h0, 32'h0000_3a5c, 32'h0000_0000, 1'b0, 22'h000000}, // sys ctrl track
    '{K_DISP,  22'h000000, 4'h0, 32'h0000_f0e1, 32'h0000_0000, 1'b0, 22'h000000},
    '{K_ROUTE, 22'h000000, 4'h0, 32'h0000_0529, 32'h0000_015e, 1'b0, 22'h000000}, // sw5 high
    '{K_ROUTE, 22'h000000, 4'h0, 32'h0000_02ac, 32'h0000_00a1, 1'b0, 22'h000000}  // sw5 low
  };

  // Standard active-high segments {g..a}, digit shows the inverse
  logic [SEG_W-1:0] seg_on [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
    7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  logic clk_50, i_rst_n;
  logic [SW_W-1:0] i_sw, o_ledr;
  logic [KEY_W-1:0] i_key, o_key_sync;
  nibble_t i_sys_status, i_spi_cs_n, i_ctrl_status;
  logic i_uart_rxd, o_uart_txd, i_ctrl_txd, o_ctrl_rxd, i_chip_txd, o_chip_rxd;
  logic i_sd_dat, i_chip_sdo, o_spi_di;
  qmem_adr_t i_m_adr, o_s_adr;
  logic i_m_cs, i_m_we, o_m_ack, o_m_err, o_s_cs, o_s_we, i_s_ack, i_s_err;
  m_sel_t i_m_sel;
  s_sel_t o_s_sel;
  m_dat_t i_m_dat_w, o_m_dat_r;
  s_dat_t o_s_dat_w, i_s_dat_r;
  track_t i_track;
  logic i_floppy_wr, i_floppy_rd, i_hd_wr, i_hd_rd;
  logic [SEG_W-1:0] o_hex0, o_hex1, o_hex2, o_hex3;
  logic [LEDG_W-1:0] o_led_g;

  s_dat_t      mem [MEM_WORDS];                   // Slave memory model
  logic [31:0] lfsr = 32'hf33;
  logic        err_on;                            // Current row flags an address
  qmem_adr_t   err_adr;
  int          mismatches = 0;
  int          timeouts = 0;

  de1_board_top dut (.*);

  initial begin
    clk_50 = 1'b0;
    forever #5 clk_50 = ~clk_50;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : (s >> 1);  // Taps 32,22,2,1
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);                     // One step per bit
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // Active-low digit for one hex value
  function automatic logic [SEG_W-1:0] digit_pattern(input nibble_t n);
    return ~seg_on[n];
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic bus_access(input row_t r, output m_dat_t rdat, output logic rerr);
    int n;
    @(posedge clk_50);
    i_m_cs    <= 1'b1;
    i_m_we    <= (r.kind == K_WR);
    i_m_adr   <= r.adr;
    i_m_sel   <= r.sel;
    i_m_dat_w <= r.dat;
    n = 0;
    do begin
      @(negedge clk_50);                          // Sample mid-cycle
      n++;
    end while (!o_m_ack && n < TIMEOUT);
    if (!o_m_ack) begin
      $display("Timeout: no m_ack within %0d cycles at address 0x%0h", TIMEOUT, r.adr);
      timeouts++;
    end
    rdat = o_m_dat_r;
    rerr = o_m_err;
    @(posedge clk_50);
    i_m_cs <= 1'b0;                               // Bridge ignores cs in ack cycle
  endtask

  task automatic show_digits(input row_t r);
    @(posedge clk_50);
    i_track       <= r.dat[7:0];
    i_ctrl_status <= r.dat[11:8];
    i_sys_status  <= r.dat[15:12];
    @(posedge clk_50);                            // Digit register
    @(negedge clk_50);
    compare("o_hex0", 32'(o_hex0), 32'(digit_pattern(r.dat[3:0])));
    compare("o_hex1", 32'(o_hex1), 32'(digit_pattern(r.dat[7:4])));
    compare("o_hex2", 32'(o_hex2), 32'(digit_pattern(r.dat[11:8])));
    repeat (SYNC_STAGES) @(posedge clk_50);       // Status goes through sync first
    @(negedge clk_50);
    compare("o_hex3", 32'(o_hex3), 32'(digit_pattern(r.dat[15:12])));
  endtask

  task automatic route_uart(input row_t r);
    @(posedge clk_50);
    i_sw       <= {4'b0, r.dat[0], 5'b0};
    i_uart_rxd <= r.dat[1];
    i_spi_cs_n <= {3'b111, r.dat[2]};
    i_sd_dat   <= r.dat[3];
    i_chip_sdo <= r.dat[4];
    i_ctrl_txd <= r.dat[5];
    i_chip_txd <= r.dat[6];
    i_key      <= r.dat[10:7];
    repeat (SYNC_STAGES) @(posedge clk_50);
    @(negedge clk_50);
    compare("o_ctrl_rxd", 32'(o_ctrl_rxd), 32'(r.want[0]));
    compare("o_chip_rxd", 32'(o_chip_rxd), 32'(r.want[1]));
    compare("o_spi_di", 32'(o_spi_di), 32'(r.want[2]));
    compare("o_uart_txd", 32'(o_uart_txd), 32'(r.want[3]));
    compare("o_ledr", 32'(o_ledr), 32'({4'b0, r.want[4], 5'b0}));
    compare("o_key_sync", 32'(o_key_sync), 32'(r.want[8:5]));
  endtask

  task automatic pulse_led(input int b);
    logic [LEDG_W-1:0] exp;
    @(posedge clk_50);
    {i_hd_rd, i_hd_wr, i_floppy_rd, i_floppy_wr} <= 4'(1 << b);
    for (int k = 0; k <= ACT_HOLD_CYCLES + 1; k++) begin
      @(negedge clk_50);
      exp = (k >= 1 && k <= ACT_HOLD_CYCLES) ? LEDG_W'(1 << b) : '0;
      compare("o_led_g", 32'(o_led_g), 32'(exp));
      @(posedge clk_50);
      {i_hd_rd, i_hd_wr, i_floppy_rd, i_floppy_wr} <= 4'b0; // Single pulse
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // 16-bit slave memory
  //////////////////////////////////////////////////////////////////////

  initial begin : mem_model
    int     d;
    int     idx;
    logic   bad;
    s_dat_t rd;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {6'h2a, 10'(i)};                   // Fill from the whole word index
    end
    i_s_ack   <= 1'b0;
    i_s_err   <= 1'b0;
    i_s_dat_r <= '0;
    forever begin
      @(negedge clk_50);
      if (o_s_cs) begin
        d = rand_bits(2);                         // 0 to 3 cycles of back-pressure
        repeat (d) @(negedge clk_50);
        idx = int'(o_s_adr[10:1]);
        bad = err_on && (o_s_adr == err_adr);
        if (!bad && o_s_we && o_s_sel[0]) mem[idx][7:0] = o_s_dat_w[7:0];
        if (!bad && o_s_we && o_s_sel[1]) mem[idx][15:8] = o_s_dat_w[15:8];
        rd = mem[idx];
        @(posedge clk_50);
        i_s_ack   <= 1'b1;
        i_s_err   <= bad;
        i_s_dat_r <= rd;
        @(posedge clk_50);
        i_s_ack <= 1'b0;
        i_s_err <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    m_dat_t rdat;
    logic   rerr;
    i_rst_n = 1'b0;
    {i_sw, i_key, i_sys_status, i_ctrl_status, i_track} = '0;
    {i_uart_rxd, i_ctrl_txd, i_chip_txd} = 3'b111; // UART lines idle high
    i_spi_cs_n = 4'hf;
    {i_sd_dat, i_chip_sdo} = 2'b0;
    {i_m_cs, i_m_we, i_m_adr, i_m_sel, i_m_dat_w} = '0;
    {i_floppy_wr, i_floppy_rd, i_hd_wr, i_hd_rd} = 4'b0;
    err_on  = 1'b0;
    err_adr = '0;
    repeat (5) @(posedge clk_50);
    i_rst_n <= 1'b1;

    for (int i = 0; i < NROWS; i++) begin
      case (rows[i].kind)
        K_WR, K_RD: begin
          err_on  = rows[i].err;
          err_adr = rows[i].bad_adr;
          bus_access(rows[i], rdat, rerr);
          compare("o_m_err", 32'(rerr), 32'(rows[i].err));
          if (rows[i].kind == K_RD && !rows[i].err) begin
            compare("o_m_dat_r", rdat, rows[i].want);
          end
        end
        K_DISP:  show_digits(rows[i]);
        default: route_uart(rows[i]);
      endcase
    end
    for (int b = 0; b < FIFO_CNT; b++) begin
      pulse_led(b);
    end

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: vlog.f
source/board_pkg.sv
source/qmem_if.sv
source/board_controls.sv
source/qmem_bridge.sv
source/board_indicators.sv
source/de1_board_top.sv
verif/tb_de1_board_top.sv

// File: Makefile
TOP = tb_de1_board_top

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim

run: build
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

lint:
	verilator --lint-only --timing -f vlog.f --top-module de1_board_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
